//--- design/console_pkg.sv
package console_pkg;

  // Screen and ring geometry
  localparam int TEXT_COLS   = 8;
  localparam int TEXT_ROWS   = 4;    // Visible lines per frame
  localparam int MEM_LINES   = 8;    // Lines kept in the ring
  localparam int FONT_HEIGHT = 2;    // Glyph rows per character
  localparam int MEM_DEPTH   = TEXT_COLS * MEM_LINES;

  localparam int ADDR_W      = 6;
  localparam int LINE_W      = 3;
  localparam int COL_W       = 3;
  localparam int FONT_ROW_W  = 1;

  typedef logic [7:0]            char_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [COL_W-1:0]      col_t;
  typedef logic [FONT_ROW_W-1:0] font_row_t;

  localparam char_t CHAR_BLANK = 8'h00;
  localparam char_t CHAR_BS    = 8'h08;
  localparam char_t CHAR_HT    = 8'h09;
  localparam char_t CHAR_CR    = 8'h0D;
  localparam char_t CHAR_DEL   = 8'h7F;

  localparam col_t COL_LAST = col_t'(TEXT_COLS - 1);  // Rightmost column

  typedef enum logic [2:0] {
    WR_CLEAR,
    WR_IDLE,
    WR_NORMAL,
    WR_BACKSPACE,
    WR_TAB,
    WR_CR,
    WR_LINE_CLEAR
  } writer_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT_WRITER,
    RD_STREAM,
    RD_DRAIN
  } reader_state_e;

  // Codes below space, plus DEL
  function automatic logic is_ctrl(char_t c);
    return (c < 8'h20) || (c == CHAR_DEL);
  endfunction

  // Cell address of a column within a ring line
  function automatic addr_t cell_addr(line_t line_idx, col_t col_idx);
    return {line_idx, col_idx};
  endfunction

endpackage

//--- design/char_mem.sv
`timescale 1ns/1ps

module char_mem (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_en,
  input  logic                i_we,
  input  console_pkg::addr_t  i_addr,
  input  console_pkg::char_t  i_wdata,
  output console_pkg::char_t  o_rdata
);
  import console_pkg::*;

  char_t mem [0:MEM_DEPTH-1];

  always_ff @(posedge clk) begin
    if (i_en && i_we) begin
      mem[i_addr] <= i_wdata;
    end
  end

  // Registered read, writes leave the output alone
  always_ff @(posedge clk) begin
    if (rst) begin
      o_rdata <= CHAR_BLANK;
    end else if (i_en && !i_we) begin
      o_rdata <= mem[i_addr];
    end
  end

endmodule

//--- design/char_mem_arbiter.sv
`timescale 1ns/1ps

module char_mem_arbiter (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_wr_req,
  input  console_pkg::addr_t  i_wr_addr,
  input  console_pkg::char_t  i_wr_data,
  input  logic                i_rd_req,
  input  console_pkg::addr_t  i_rd_addr,
  output logic                o_rd_grant,
  output logic                o_rd_data_vld,
  output console_pkg::char_t  o_rd_data,
  output logic                o_mem_en,
  output logic                o_mem_we,
  output console_pkg::addr_t  o_mem_addr,
  output console_pkg::char_t  o_mem_wdata,
  input  console_pkg::char_t  i_mem_rdata
);

  // Writer always wins the port
  assign o_rd_grant  = i_rd_req && !i_wr_req;

  assign o_mem_en    = i_wr_req || i_rd_req;
  assign o_mem_we    = i_wr_req;
  assign o_mem_addr  = i_wr_req ? i_wr_addr : i_rd_addr;
  assign o_mem_wdata = i_wr_data;

  // Memory output belongs to the reader only after a granted read
  always_ff @(posedge clk) begin
    if (rst) begin
      o_rd_data_vld <= 1'b0;
    end else begin
      o_rd_data_vld <= o_rd_grant;
    end
  end

  assign o_rd_data = i_mem_rdata;

endmodule

//--- design/char_writer.sv
`timescale 1ns/1ps

module char_writer (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_char_stb,
  input  console_pkg::char_t  i_char,
  input  logic                i_alt_func_en,
  input  logic [2:0]          i_tab_count,
  input  logic                i_clear_screen_stb,
  output logic                o_busy,
  output logic                o_wr_req,
  output console_pkg::addr_t  o_wr_addr,
  output console_pkg::char_t  o_wr_data,
  output console_pkg::line_t  o_top_line
);
  import console_pkg::*;

  writer_state_e   state;
  char_t           char_q;
  col_t            col;
  line_t           cur_line;     // Ring index of the cursor line
  logic            scrolled;     // Cursor has gone past the last visible row
  logic [2:0]      tab_left;
  logic [ADDR_W:0] blk_cnt;      // Cell counter for full and line clears
  logic            col_last;
  logic            step;         // Cursor advances this cycle

  assign col_last = (col == COL_LAST);
  assign step     = (state == WR_NORMAL) || (state == WR_CR) ||
                    ((state == WR_TAB) && (tab_left != '0));
  assign o_busy   = (state != WR_IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= WR_CLEAR;
      tab_left <= '0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (i_clear_screen_stb) begin
            state <= WR_CLEAR;
          end else if (i_char_stb) begin
            if (i_alt_func_en || !is_ctrl(i_char)) begin
              state <= WR_NORMAL;   // Raw store in alternate mode
            end else begin
              case (i_char)
                CHAR_BS: begin
                  state <= WR_BACKSPACE;
                end
                CHAR_HT: begin
                  tab_left <= i_tab_count;
                  state    <= WR_TAB;
                end
                CHAR_CR: begin
                  state <= WR_CR;
                end
                default: begin
                  state <= WR_IDLE;   // LF and the rest are dropped
                end
              endcase
            end
          end
        end
        WR_NORMAL: begin
          state <= col_last ? WR_LINE_CLEAR : WR_IDLE;
        end
        WR_BACKSPACE: begin
          state <= WR_IDLE;
        end
        WR_TAB: begin
          if (tab_left == '0) begin
            state <= WR_IDLE;
          end else begin
            tab_left <= tab_left - 1'b1;
            if (col_last) begin
              state <= WR_LINE_CLEAR;
            end
          end
        end
        WR_CR: begin
          if (col_last) begin
            state <= WR_LINE_CLEAR;
          end
        end
        WR_LINE_CLEAR: begin
          // Resume a tab that ran over the line end
          if (blk_cnt[COL_W-1:0] == COL_LAST) begin
            state <= (tab_left != '0) ? WR_TAB : WR_IDLE;
          end
        end
        WR_CLEAR: begin
          if (blk_cnt == (ADDR_W + 1)'(MEM_DEPTH)) begin
            state <= WR_IDLE;
          end
        end
        default: begin
          state <= WR_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == WR_IDLE && i_char_stb) begin
      char_q <= i_char;
    end
  end

  // Counts only while a clear runs
  always_ff @(posedge clk) begin
    if (rst) begin
      blk_cnt <= '0;
    end else if (state == WR_CLEAR || state == WR_LINE_CLEAR) begin
      blk_cnt <= blk_cnt + 1'b1;
    end else begin
      blk_cnt <= '0;
    end
  end

  // Cursor and line ring bookkeeping
  always_ff @(posedge clk) begin
    if (rst || state == WR_CLEAR) begin
      col      <= '0;
      cur_line <= '0;
      scrolled <= 1'b0;
    end else if (step) begin
      if (col_last) begin
        col      <= '0;
        cur_line <= cur_line + 1'b1;
        if (cur_line >= line_t'(TEXT_ROWS - 1)) begin
          scrolled <= 1'b1;
        end
      end else begin
        col <= col + 1'b1;
      end
    end else if (state == WR_BACKSPACE && col != '0) begin
      col <= col - 1'b1;   // Stops at column 0
    end
  end

  // Window ends on the cursor line once the screen has filled
  assign o_top_line = scrolled ? (cur_line - line_t'(TEXT_ROWS - 1)) : '0;

  always_comb begin
    o_wr_req  = 1'b0;
    o_wr_addr = cell_addr(cur_line, col);
    o_wr_data = CHAR_BLANK;
    case (state)
      WR_CLEAR: begin
        o_wr_req  = (blk_cnt < (ADDR_W + 1)'(MEM_DEPTH));
        o_wr_addr = blk_cnt[ADDR_W-1:0];
      end
      WR_NORMAL: begin
        o_wr_req  = 1'b1;
        o_wr_data = char_q;
      end
      WR_BACKSPACE: begin
        o_wr_req  = (col != '0);
        o_wr_addr = cell_addr(cur_line, col - 1'b1);
      end
      WR_TAB: begin
        o_wr_req = (tab_left != '0);
      end
      WR_CR: begin
        o_wr_req = 1'b1;   // Blank from cursor to line end
      end
      WR_LINE_CLEAR: begin
        o_wr_req  = 1'b1;
        o_wr_addr = cell_addr(cur_line, blk_cnt[COL_W-1:0]);
      end
      default: begin
        o_wr_req = 1'b0;
      end
    endcase
  end

endmodule

//--- design/frame_reader.sv
`timescale 1ns/1ps

module frame_reader (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_read_frame_stb,
  input  logic                    i_char_req_en,
  input  logic                    i_writer_busy,
  input  console_pkg::line_t      i_top_line,
  output logic                    o_rd_req,
  output console_pkg::addr_t      o_rd_addr,
  input  logic                    i_rd_grant,
  input  logic                    i_rd_data_vld,
  input  console_pkg::char_t      i_rd_data,
  output logic                    o_char_rdy,
  output console_pkg::char_t      o_char,
  output console_pkg::font_row_t  o_font_row,
  output logic                    o_frame_done
);
  import console_pkg::*;

  reader_state_e state;
  line_t         base_line;    // First visible ring line for this frame
  line_t         line_cnt;
  col_t          col;
  font_row_t     font_row;
  font_row_t     tag_q;        // Glyph row of the read inside the memory
  logic          req_taken;
  logic          font_last;
  logic          line_last;

  assign o_rd_req  = (state == RD_STREAM) && i_char_req_en;
  assign o_rd_addr = cell_addr(base_line + line_cnt, col);
  assign req_taken = o_rd_req && i_rd_grant;
  assign font_last = (font_row == font_row_t'(FONT_HEIGHT - 1));
  assign line_last = (line_cnt == line_t'(TEXT_ROWS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= RD_IDLE;
      base_line    <= '0;
      line_cnt     <= '0;
      col          <= '0;
      font_row     <= '0;
      o_frame_done <= 1'b0;
    end else begin
      o_frame_done <= 1'b0;
      case (state)
        RD_IDLE: begin
          if (i_read_frame_stb) begin
            line_cnt <= '0;
            col      <= '0;
            font_row <= '0;
            if (i_writer_busy) begin
              state <= RD_WAIT_WRITER;
            end else begin
              base_line <= i_top_line;
              state     <= RD_STREAM;
            end
          end
        end
        RD_WAIT_WRITER: begin
          if (!i_writer_busy) begin
            base_line <= i_top_line;
            state     <= RD_STREAM;
          end
        end
        RD_STREAM: begin
          // Counters move only on a granted read, so a denied address holds
          if (req_taken) begin
            if (col == COL_LAST) begin
              col <= '0;
              if (font_last) begin
                font_row <= '0;
                if (line_last) begin
                  state <= RD_DRAIN;
                end else begin
                  line_cnt <= line_cnt + 1'b1;
                end
              end else begin
                font_row <= font_row + 1'b1;   // Same line again
              end
            end else begin
              col <= col + 1'b1;
            end
          end
        end
        RD_DRAIN: begin
          // Last read has reached the output register
          if (!i_rd_data_vld) begin
            o_frame_done <= 1'b1;
            state        <= RD_IDLE;
          end
        end
        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_char_rdy <= 1'b0;
    end else begin
      o_char_rdy <= i_rd_data_vld;
    end
  end

  // Row tag follows its character through the memory
  always_ff @(posedge clk) begin
    if (req_taken) begin
      tag_q <= font_row;
    end
    if (i_rd_data_vld) begin
      o_char     <= i_rd_data;
      o_font_row <= tag_q;
    end
  end

endmodule

//--- design/console_char_buffer.sv
`timescale 1ns/1ps

module console_char_buffer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_char_stb,
  input  console_pkg::char_t      i_char,
  input  logic                    i_alt_func_en,
  input  logic [2:0]              i_tab_count,
  input  logic                    i_clear_screen_stb,
  input  logic                    i_read_frame_stb,
  input  logic                    i_char_req_en,
  output logic                    o_busy,
  output logic                    o_char_rdy,
  output console_pkg::char_t      o_char,
  output console_pkg::font_row_t  o_font_row,
  output logic                    o_frame_done
);
  import console_pkg::*;

  // Writer side
  logic  wr_req;
  addr_t wr_addr;
  char_t wr_data;
  line_t top_line;

  // Reader side
  logic  rd_req;
  addr_t rd_addr;
  logic  rd_grant;
  logic  rd_data_vld;
  char_t rd_data;

  // Memory port
  logic  mem_en;
  logic  mem_we;
  addr_t mem_addr;
  char_t mem_wdata;
  char_t mem_rdata;

  char_writer u_writer (
    .clk                (clk),
    .rst                (rst),
    .i_char_stb         (i_char_stb),
    .i_char             (i_char),
    .i_alt_func_en      (i_alt_func_en),
    .i_tab_count        (i_tab_count),
    .i_clear_screen_stb (i_clear_screen_stb),
    .o_busy             (o_busy),
    .o_wr_req           (wr_req),
    .o_wr_addr          (wr_addr),
    .o_wr_data          (wr_data),
    .o_top_line         (top_line)
  );

  frame_reader u_reader (
    .clk              (clk),
    .rst              (rst),
    .i_read_frame_stb (i_read_frame_stb),
    .i_char_req_en    (i_char_req_en),
    .i_writer_busy    (o_busy),
    .i_top_line       (top_line),
    .o_rd_req         (rd_req),
    .o_rd_addr        (rd_addr),
    .i_rd_grant       (rd_grant),
    .i_rd_data_vld    (rd_data_vld),
    .i_rd_data        (rd_data),
    .o_char_rdy       (o_char_rdy),
    .o_char           (o_char),
    .o_font_row       (o_font_row),
    .o_frame_done     (o_frame_done)
  );

  char_mem_arbiter u_arbiter (
    .clk           (clk),
    .rst           (rst),
    .i_wr_req      (wr_req),
    .i_wr_addr     (wr_addr),
    .i_wr_data     (wr_data),
    .i_rd_req      (rd_req),
    .i_rd_addr     (rd_addr),
    .o_rd_grant    (rd_grant),
    .o_rd_data_vld (rd_data_vld),
    .o_rd_data     (rd_data),
    .o_mem_en      (mem_en),
    .o_mem_we      (mem_we),
    .o_mem_addr    (mem_addr),
    .o_mem_wdata   (mem_wdata),
    .i_mem_rdata   (mem_rdata)
  );

  char_mem u_mem (
    .clk     (clk),
    .rst     (rst),
    .i_en    (mem_en),
    .i_we    (mem_we),
    .i_addr  (mem_addr),
    .i_wdata (mem_wdata),
    .o_rdata (mem_rdata)
  );

endmodule

//--- verif/tb_console_pkg_model.svh
`ifndef TB_CONSOLE_PKG_MODEL_SVH
`define TB_CONSOLE_PKG_MODEL_SVH

  char_t model_mem [0:MEM_DEPTH-1];   // Expected ring contents
  int    model_col;
  int    model_line;                  // Absolute line, never wraps

  function automatic int model_cell(int abs_line, int col);
    return (abs_line % MEM_LINES) * TEXT_COLS + col;
  endfunction

  function automatic void model_blank_line(int abs_line);
    for (int c = 0; c < TEXT_COLS; c++) begin
      model_mem[model_cell(abs_line, c)] = CHAR_BLANK;
    end
  endfunction

  function automatic void model_clear();
    for (int a = 0; a < MEM_DEPTH; a++) begin
      model_mem[a] = CHAR_BLANK;
    end
    model_col  = 0;
    model_line = 0;
  endfunction

  // Store at the cursor and step, a fresh line gets blanked
  function automatic void model_put(char_t c);
    model_mem[model_cell(model_line, model_col)] = c;
    model_col++;
    if (model_col == TEXT_COLS) begin
      model_col = 0;
      model_line++;
      model_blank_line(model_line);
    end
  endfunction

  function automatic void model_apply(char_t c, logic alt, logic [2:0] tab);
    int start_line;
    start_line = model_line;
    if (alt || (c >= 8'h20 && c != CHAR_DEL)) begin
      model_put(c);
    end else if (c == CHAR_BS) begin
      if (model_col > 0) begin
        model_col--;
        model_mem[model_cell(model_line, model_col)] = CHAR_BLANK;
      end
    end else if (c == CHAR_HT) begin
      for (int i = 0; i < int'(tab); i++) begin
        model_put(CHAR_BLANK);
      end
    end else if (c == CHAR_CR) begin
      while (model_line == start_line) begin
        model_put(CHAR_BLANK);   // Rest of line, then on to the next
      end
    end
  endfunction

  // Window ends on the cursor line
  function automatic int model_top();
    if (model_line < TEXT_ROWS) begin
      return 0;
    end
    return (model_line - TEXT_ROWS + 1) % MEM_LINES;
  endfunction

  function automatic char_t window_char(int vis_row, int col);
    return model_mem[model_cell(model_top() + vis_row, col)];
  endfunction

  task automatic check_char(string name, char_t exp, char_t act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected %02h actual %02h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_font_row(string name, font_row_t exp, font_row_t act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (act != exp) begin
      $display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

`endif

//--- verif/tb_console.sv
`timescale 1ns/1ps

module tb_console;
  import console_pkg::*;

  localparam int CLK_HALF    = 4;
  localparam int BUSY_LIMIT  = 200;
  localparam int FRAME_LIMIT = 2000;
  localparam int FRAME_CHARS = TEXT_ROWS * FONT_HEIGHT * TEXT_COLS;

  logic        clk;
  logic        rst;
  logic        i_char_stb;
  char_t       i_char;
  logic        i_alt_func_en;
  logic [2:0]  i_tab_count;
  logic        i_clear_screen_stb;
  logic        i_read_frame_stb;
  logic        i_char_req_en;
  logic        o_busy;
  logic        o_char_rdy;
  char_t       o_char;
  font_row_t   o_font_row;
  logic        o_frame_done;
  logic [31:0] rng_state;
  int          busy_cycles;   // Length of the last busy period seen

  console_char_buffer i_dut (
    .clk                (clk),
    .rst                (rst),
    .i_char_stb         (i_char_stb),
    .i_char             (i_char),
    .i_alt_func_en      (i_alt_func_en),
    .i_tab_count        (i_tab_count),
    .i_clear_screen_stb (i_clear_screen_stb),
    .i_read_frame_stb   (i_read_frame_stb),
    .i_char_req_en      (i_char_req_en),
    .o_busy             (o_busy),
    .o_char_rdy         (o_char_rdy),
    .o_char             (o_char),
    .o_font_row         (o_font_row),
    .o_frame_done       (o_frame_done)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  `include "tb_console_pkg_model.svh"

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic wait_idle();
    int cyc;
    cyc = 0;
    @(negedge clk);
    while (o_busy) begin
      if (cyc == BUSY_LIMIT) begin
        $display("Timeout: o_busy stayed high for %0d cycles", BUSY_LIMIT);
        abort_run();
      end
      cyc++;
      @(negedge clk);
    end
    busy_cycles = cyc;
  endtask

  task automatic send_char(char_t c, logic alt, logic [2:0] tab);
    @(posedge clk);
    i_char_stb    <= 1'b1;
    i_char        <= c;
    i_alt_func_en <= alt;
    i_tab_count   <= tab;
    @(posedge clk);
    i_char_stb <= 1'b0;
    wait_idle();
    model_apply(c, alt, tab);
  endtask

  task automatic send_text(string s);
    for (int i = 0; i < s.len(); i++) begin
      send_char(char_t'(s[i]), 1'b0, 3'd0);
    end
  endtask

  task automatic send_random_tab();
    rng_state = xorshift32(rng_state);
    send_char(CHAR_HT, 1'b0, rng_state[2:0]);
  endtask

  task automatic clear_screen();
    @(posedge clk);
    i_clear_screen_stb <= 1'b1;
    @(posedge clk);
    i_clear_screen_stb <= 1'b0;
    wait_idle();
    model_clear();
  endtask

  // One frame against the model window with optional random back-pressure
  task automatic read_and_check_frame(bit toggle_en);
    int   cyc;
    int   got;
    int   last_rdy;
    bit   done;
    logic en_now;
    logic en_d1;
    logic en_d2;
    cyc      = 0;
    got      = 0;
    last_rdy = -10;
    done     = 1'b0;
    en_now   = 1'b1;
    en_d1    = 1'b1;
    en_d2    = 1'b1;
    while (!done) begin
      @(posedge clk);
      i_read_frame_stb <= (cyc == 0);
      en_d2 = en_d1;
      en_d1 = en_now;
      if (toggle_en) begin
        rng_state = xorshift32(rng_state);
        en_now    = rng_state[0] | rng_state[1];   // On about 3 of 4 cycles
      end
      i_char_req_en <= en_now;
      @(negedge clk);
      if (o_char_rdy) begin
        if (!en_d2) begin
          $display("o_char_rdy pulsed at %0t with no read issued two cycles before", $time);
          abort_run();
        end
        if (got == FRAME_CHARS) begin
          $display("More than %0d o_char_rdy pulses in one frame", FRAME_CHARS);
          abort_run();
        end
        check_char("o_char", window_char(got / (FONT_HEIGHT * TEXT_COLS), got % TEXT_COLS),
                   o_char);
        check_font_row("o_font_row", font_row_t'((got / TEXT_COLS) % FONT_HEIGHT), o_font_row);
        got++;
        last_rdy = cyc;
      end
      if (o_frame_done) begin
        check_count("o_char_rdy pulse count", FRAME_CHARS, got);
        check_count("o_frame_done delay", 1, cyc - last_rdy);
        done = 1'b1;
      end else if (cyc == FRAME_LIMIT) begin
        $display("Timeout: no o_frame_done within %0d cycles", FRAME_LIMIT);
        abort_run();
      end
      cyc++;
    end
    @(posedge clk);
    i_char_req_en <= 1'b1;
    @(negedge clk);
    check_count("o_frame_done after frame", 0, int'(o_frame_done));
    check_count("o_char_rdy after frame", 0, int'(o_char_rdy));
  endtask

  task automatic test_reset_blank();
    check_count("o_char_rdy after reset", 0, int'(o_char_rdy));
    check_count("o_frame_done after reset", 0, int'(o_frame_done));
    read_and_check_frame(1'b0);
  endtask

  task automatic write_sample_text();
    send_text("Hi");
    send_random_tab();
    send_text("ok");
    send_char(CHAR_CR, 1'b0, 3'd0);
    send_text("line2");
    send_char(CHAR_CR, 1'b0, 3'd0);
    send_random_tab();
    send_text("abc");
  endtask

  task automatic test_text_tab_cr();
    write_sample_text();
    read_and_check_frame(1'b0);
  endtask

  task automatic test_backspace_ctrl();
    send_char(CHAR_CR, 1'b0, 3'd0);
    send_text("xy");
    repeat (3) send_char(CHAR_BS, 1'b0, 3'd0);   // Third one sits at column 0
    send_text("z");
    send_char(8'h01, 1'b0, 3'd0);   // Dropped
    send_char(8'h01, 1'b1, 3'd0);   // Stored raw
    send_char(CHAR_BS, 1'b1, 3'd0);
    send_text("w");
    read_and_check_frame(1'b0);
  endtask

  task automatic test_scroll_wrap();
    for (int i = 0; i < 12; i++) begin
      send_text($sformatf("row%0d", i));
      send_char(CHAR_CR, 1'b0, 3'd0);
      if (i == 4 || i == 11) begin
        read_and_check_frame(1'b0);   // Cursor line is a fresh blank one
      end
    end
    send_text("ABCDEFGHIJ");   // Overflow into a reused line
    read_and_check_frame(1'b0);
  endtask

  task automatic test_clear();
    clear_screen();
    read_and_check_frame(1'b0);
  endtask

  task automatic test_backpressure();
    write_sample_text();
    read_and_check_frame(1'b1);
    read_and_check_frame(1'b1);
  endtask

  initial begin
    rng_state          = 32'd91;
    rst                = 1'b1;
    i_char_stb         = 1'b0;
    i_char             = CHAR_BLANK;
    i_alt_func_en      = 1'b0;
    i_tab_count        = 3'd0;
    i_clear_screen_stb = 1'b0;
    i_read_frame_stb   = 1'b0;
    i_char_req_en      = 1'b1;
    busy_cycles        = 0;
    model_clear();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    wait_idle();   // Power-up clear
    check_count("o_busy cycles after reset", MEM_DEPTH + 1, busy_cycles);
    test_reset_blank();
    test_text_tab_cr();
    test_backspace_ctrl();
    test_scroll_wrap();
    test_clear();
    test_backpressure();
    $display("sim passed");
    $finish;
  end

endmodule

//--- console_text.f
+incdir+verif
design/console_pkg.sv
design/char_mem.sv
design/char_mem_arbiter.sv
design/char_writer.sv
design/frame_reader.sv
design/console_char_buffer.sv
verif/tb_console.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_console \
  -f console_text.f

status=0
sim_out=$(./obj_dir/Vtb_console 2>&1) || status=$?
echo "$sim_out"

if grep -qx "sim passed" <<< "$sim_out"; then
  exit 0
fi

echo "Simulation did not pass, exit status ${status}"
exit 1
